/* src/l2_addr_pkg.sv */
`default_nettype none

package l2_addr_pkg;

	// ====================
	// cache geometry
	// ====================
	localparam int line_bits = 256;
	localparam int tag_bits = 24;
	localparam int index_bits = 3;
	localparam int offset_bits = 5;
	localparam int num_sets = 1 << index_bits;

	typedef struct packed
	{
		logic [tag_bits-1:0] tag;
		logic [index_bits-1:0] index;
		logic [offset_bits-1:0] offset;
	} l2_addr_fields_t;

	// one address word that is seen either raw or split into lookup fields
	typedef union packed
	{
		logic [31:0] word;
		l2_addr_fields_t fields;
	} l2_addr_u;

endpackage

`default_nettype wire

/* src/l2_ctrl_pkg.sv */
`default_nettype none

package l2_ctrl_pkg;

	// controller states for the hit, writeback and fill phases
	typedef enum logic [1:0]
	{
		hit_state = 2'b00,
		evict_state = 2'b01,
		allocate_state = 2'b10
	} l2_state_e;

endpackage

`default_nettype wire

/* src/l2_cache_control.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_control
#(
	parameter int miss_count_bits = 32
)
(
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic cache_hit,
	input logic dirtyout,
	output logic pmem_read,
	output logic pmem_write,
	output logic mem_resp,
	output logic datain_mux_sel,
	output logic write_enable,
	output logic valid_in,
	output logic dirty_datain,
	output logic cache_allocate,
	output logic pmem_address_sel,
	output logic addr_reg_load,
	output logic evict_allocate,
	output logic [miss_count_bits-1:0] miss_count
);

	l2_ctrl_pkg::l2_state_e state;
	l2_ctrl_pkg::l2_state_e next_state;

	// ====================
	// state actions
	// ====================
	always_comb
	begin
		datain_mux_sel = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		write_enable = 1'b0;
		valid_in = 1'b0;
		mem_resp = 1'b0;
		cache_allocate = 1'b0;
		dirty_datain = 1'b0;
		pmem_address_sel = 1'b0;
		evict_allocate = 1'b0;
		unique case (state)
			l2_ctrl_pkg::hit_state:
			begin
				if (cache_hit && (mem_read || mem_write))
				begin
					// a read hit leaves the dirty bit as it was
					if (mem_read)
					begin
						dirty_datain = dirtyout;
					end
					else
					begin
						write_enable = 1'b1;
						dirty_datain = 1'b1;
						datain_mux_sel = 1'b1;
						valid_in = 1'b1;
					end
					mem_resp = 1'b1;
				end
			end
			l2_ctrl_pkg::allocate_state:
			begin
				pmem_read = 1'b1;
				evict_allocate = 1'b1;
				if (pmem_resp)
				begin
					valid_in = 1'b1;
					write_enable = 1'b1;
					cache_allocate = 1'b1;
				end
			end
			l2_ctrl_pkg::evict_state:
			begin
				// the victim line goes out under its own tag
				evict_allocate = 1'b1;
				pmem_address_sel = 1'b1;
				pmem_write = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// ====================
	// next state
	// ====================
	always_comb
	begin
		next_state = state;
		addr_reg_load = 1'b0;
		case (state)
			l2_ctrl_pkg::hit_state:
			begin
				if (!mem_resp && (mem_read || mem_write))
				begin
					if (dirtyout)
						next_state = l2_ctrl_pkg::evict_state;
					else
						next_state = l2_ctrl_pkg::allocate_state;
					addr_reg_load = 1'b1;
				end
			end
			l2_ctrl_pkg::allocate_state:
			begin
				if (pmem_resp)
					next_state = l2_ctrl_pkg::hit_state;
			end
			l2_ctrl_pkg::evict_state:
			begin
				if (pmem_resp)
					next_state = l2_ctrl_pkg::allocate_state;
			end
			default:
			begin
				next_state = l2_ctrl_pkg::hit_state;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= l2_ctrl_pkg::hit_state;
			miss_count <= '0;
		end
		else
		begin
			state <= next_state;
			// one count for each entry into allocate_state
			if (next_state == l2_ctrl_pkg::allocate_state &&
				state != l2_ctrl_pkg::allocate_state)
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/l2_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_tag_array
(
	input logic clk,
	input logic rst,
	input l2_addr_pkg::l2_addr_u address,
	input logic write_enable,
	input logic valid_in,
	input logic dirty_datain,
	input logic cache_allocate,
	output logic cache_hit,
	output logic dirtyout,
	output logic [l2_addr_pkg::tag_bits-1:0] victim_tag
);

	logic [l2_addr_pkg::tag_bits-1:0] tags [l2_addr_pkg::num_sets];
	logic [l2_addr_pkg::num_sets-1:0] valid;
	logic [l2_addr_pkg::num_sets-1:0] dirty;

	logic [l2_addr_pkg::index_bits-1:0] set_index;
	logic [l2_addr_pkg::tag_bits-1:0] stored_tag;

	assign set_index = address.fields.index;
	assign stored_tag = tags[set_index];

	// ====================
	// lookup
	// ====================
	always_comb
	begin
		cache_hit = valid[set_index] && (stored_tag == address.fields.tag);
		dirtyout = dirty[set_index];
		victim_tag = stored_tag;
	end

	always_ff @(posedge clk)
	begin
		if (write_enable)
			tags[set_index] <= address.fields.tag;
	end

	// ====================
	// status bits
	// ====================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else if (write_enable)
		begin
			valid[set_index] <= valid_in;
			// a freshly filled line matches memory
			if (cache_allocate)
				dirty[set_index] <= 1'b0;
			else
				dirty[set_index] <= dirty_datain;
		end
	end

endmodule

`default_nettype wire

/* src/l2_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_data_array
(
	input logic clk,
	input logic write_enable,
	input logic datain_mux_sel,
	input logic [l2_addr_pkg::index_bits-1:0] index,
	input logic [l2_addr_pkg::line_bits-1:0] mem_wdata,
	input logic [l2_addr_pkg::line_bits-1:0] pmem_rdata,
	output logic [l2_addr_pkg::line_bits-1:0] line_out
);

	logic [l2_addr_pkg::line_bits-1:0] lines [l2_addr_pkg::num_sets];
	logic [l2_addr_pkg::line_bits-1:0] write_line;

	// ====================
	// write path
	// ====================

	// a write hit stores the L1 line and a fill stores the memory line
	always_comb
	begin
		if (datain_mux_sel)
			write_line = mem_wdata;
		else
			write_line = pmem_rdata;
	end

	always_ff @(posedge clk)
	begin
		if (write_enable)
			lines[index] <= write_line;
	end

	// ====================
	// read path
	// ====================

	// the same line feeds the L1 read data and the writeback data
	assign line_out = lines[index];

endmodule

`default_nettype wire

/* src/l2_pmem_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_pmem_addr_gen
(
	input logic clk,
	input logic rst,
	input l2_addr_pkg::l2_addr_u mem_address,
	input logic addr_reg_load,
	input logic evict_allocate,
	input logic pmem_address_sel,
	input logic [l2_addr_pkg::tag_bits-1:0] victim_tag,
	output l2_addr_pkg::l2_addr_u pmem_address,
	output l2_addr_pkg::l2_addr_u lookup_address
);

	l2_addr_pkg::l2_addr_u miss_addr;

	// holds the request address for the whole miss
	always_ff @(posedge clk)
	begin
		if (rst)
			miss_addr.word <= '0;
		else if (addr_reg_load)
			miss_addr <= mem_address;
	end

	assign lookup_address = evict_allocate ? miss_addr : mem_address;

	always_comb
	begin
		pmem_address = miss_addr;
		pmem_address.fields.offset = '0;
		// writebacks go to the line the victim came from
		if (pmem_address_sel)
			pmem_address.fields.tag = victim_tag;
	end

endmodule

`default_nettype wire

/* src/l2_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache
#(
	parameter int miss_count_bits = 32
)
(
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input l2_addr_pkg::l2_addr_u mem_address,
	input logic [l2_addr_pkg::line_bits-1:0] mem_wdata,
	output logic [l2_addr_pkg::line_bits-1:0] mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output l2_addr_pkg::l2_addr_u pmem_address,
	output logic [l2_addr_pkg::line_bits-1:0] pmem_wdata,
	input logic [l2_addr_pkg::line_bits-1:0] pmem_rdata,
	input logic pmem_resp,
	output logic [miss_count_bits-1:0] miss_count
);

	logic write_enable;
	logic valid_in;
	logic dirty_datain;
	logic datain_mux_sel;
	logic cache_allocate;
	logic addr_reg_load;
	logic pmem_address_sel;
	logic evict_allocate;
	logic cache_hit;
	logic dirtyout;
	logic [l2_addr_pkg::tag_bits-1:0] victim_tag;
	l2_addr_pkg::l2_addr_u lookup_address;
	logic [l2_addr_pkg::line_bits-1:0] line_data;

	assign mem_rdata = line_data;
	assign pmem_wdata = line_data;

	// ====================
	// control
	// ====================
	l2_cache_control #(.miss_count_bits(miss_count_bits)) control
	(
		.clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
		.pmem_resp(pmem_resp), .cache_hit(cache_hit), .dirtyout(dirtyout),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .mem_resp(mem_resp),
		.datain_mux_sel(datain_mux_sel), .write_enable(write_enable),
		.valid_in(valid_in), .dirty_datain(dirty_datain),
		.cache_allocate(cache_allocate), .pmem_address_sel(pmem_address_sel),
		.addr_reg_load(addr_reg_load), .evict_allocate(evict_allocate),
		.miss_count(miss_count)
	);

	// ====================
	// datapath
	// ====================
	l2_tag_array tag_array
	(
		.clk(clk), .rst(rst), .address(lookup_address),
		.write_enable(write_enable), .valid_in(valid_in),
		.dirty_datain(dirty_datain), .cache_allocate(cache_allocate),
		.cache_hit(cache_hit), .dirtyout(dirtyout), .victim_tag(victim_tag)
	);

	l2_data_array data_array
	(
		.clk(clk), .write_enable(write_enable), .datain_mux_sel(datain_mux_sel),
		.index(lookup_address.fields.index), .mem_wdata(mem_wdata),
		.pmem_rdata(pmem_rdata), .line_out(line_data)
	);

	l2_pmem_addr_gen addr_gen
	(
		.clk(clk), .rst(rst), .mem_address(mem_address),
		.addr_reg_load(addr_reg_load), .evict_allocate(evict_allocate),
		.pmem_address_sel(pmem_address_sel), .victim_tag(victim_tag),
		.pmem_address(pmem_address), .lookup_address(lookup_address)
	);

endmodule

`default_nettype wire

/* sim/l2_cache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_assertions
(
	input logic clk,
	input logic rst,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic mem_resp,
	input l2_ctrl_pkg::l2_state_e state
);

	// the memory bus carries one direction at a time
	no_read_and_write: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write are high together");

	resp_only_in_hit: assert property (@(posedge clk) disable iff (rst)
		mem_resp |-> state == l2_ctrl_pkg::hit_state)
		else $error("mem_resp raised outside hit_state");

	// a memory read stays up until the memory answers
	read_held: assert property (@(posedge clk) disable iff (rst)
		pmem_read && !pmem_resp |=> pmem_read)
		else $error("pmem_read dropped before pmem_resp");

endmodule

bind l2_cache_control l2_cache_assertions protocol_checks
(
	.clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
	.pmem_resp(pmem_resp), .mem_resp(mem_resp), .state(state)
);

`default_nettype wire

/* sim/l2_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb;

	localparam int miss_count_bits = 32;
	localparam int line_bits = l2_addr_pkg::line_bits;
	localparam int reset_cycles = 8;
	localparam int resp_timeout = 200;
	localparam int pattern_words = 64;
	localparam int record_words = 5;
	localparam logic [7:0] op_read = 8'd1;
	localparam logic [7:0] op_write = 8'd2;

	logic clk = 1'b0;
	logic rst;
	logic mem_read;
	logic mem_write;
	l2_addr_pkg::l2_addr_u mem_address;
	logic [line_bits-1:0] mem_wdata;
	logic [line_bits-1:0] mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	l2_addr_pkg::l2_addr_u pmem_address;
	logic [line_bits-1:0] pmem_wdata;
	logic [line_bits-1:0] pmem_rdata = '0;
	logic pmem_resp = 1'b0;
	logic [miss_count_bits-1:0] miss_count;

	logic [line_bits-1:0] patterns [0:pattern_words-1];

	// reference view of the cache and of what memory should hold
	logic [l2_addr_pkg::tag_bits-1:0] ref_tag [l2_addr_pkg::num_sets];
	logic [line_bits-1:0] ref_line [l2_addr_pkg::num_sets];
	logic [l2_addr_pkg::num_sets-1:0] ref_valid;
	logic [l2_addr_pkg::num_sets-1:0] ref_dirty;
	logic [line_bits-1:0] ref_mem [logic [31:0]];
	int ref_misses;

	l2_cache #(.miss_count_bits(miss_count_bits)) DUT
	(
		.clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
		.mem_address(mem_address), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp), .miss_count(miss_count)
	);

	always #4 clk = ~clk;

	// ====================
	// physical memory
	// ====================
	logic [line_bits-1:0] pmem_store [logic [31:0]];
	integer seed = 32'hbbe3;
	int mem_wait = 0;
	logic mem_busy = 1'b0;
	int fill_count = 0;
	int wb_count = 0;
	l2_addr_pkg::l2_addr_u last_wb_addr;
	logic [line_bits-1:0] last_wb_data;

	// a line never written back reads as its own address in every word
	function automatic logic [line_bits-1:0] untouched_line(input logic [31:0] line_addr);
		return {8{line_addr}};
	endfunction

	function automatic logic [line_bits-1:0] memory_line(input logic [31:0] line_addr);
		if (pmem_store.exists(line_addr))
			return pmem_store[line_addr];
		return untouched_line(line_addr);
	endfunction

	function automatic logic [line_bits-1:0] expected_memory_line(input logic [31:0] line_addr);
		if (ref_mem.exists(line_addr))
			return ref_mem[line_addr];
		return untouched_line(line_addr);
	endfunction

	always @(posedge clk)
	begin
		if (rst)
		begin
			pmem_resp <= 1'b0;
			mem_busy = 1'b0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			// no new access starts on the edge that ends a response
			if (!mem_busy && !pmem_resp && (pmem_read || pmem_write))
			begin
				mem_busy = 1'b1;
				mem_wait = $unsigned($random(seed)) % 4 + 1;
			end
			if (mem_busy)
			begin
				mem_wait = mem_wait - 1;
				if (mem_wait == 0)
				begin
					mem_busy = 1'b0;
					pmem_resp <= 1'b1;
					if (pmem_write)
					begin
						pmem_store[pmem_address.word] = pmem_wdata;
						last_wb_addr = pmem_address;
						last_wb_data = pmem_wdata;
						wb_count = wb_count + 1;
					end
					else
					begin
						pmem_rdata <= memory_line(pmem_address.word);
						fill_count = fill_count + 1;
					end
				end
			end
		end
	end

	// ====================
	// compare tasks
	// ====================
	task automatic check_line(input string name, input logic [line_bits-1:0] expected,
		input logic [line_bits-1:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "line compare failed");
		end
	endtask

	task automatic check_addr(input string name, input l2_addr_pkg::l2_addr_u expected,
		input l2_addr_pkg::l2_addr_u actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected.word, actual.word);
			$display("Simulation FAILED");
			$fatal(1, "address compare failed");
		end
	endtask

	task automatic check_count(input string name, input logic [miss_count_bits-1:0] expected,
		input logic [miss_count_bits-1:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "count compare failed");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "flag compare failed");
		end
	endtask

	task automatic report_timeout(input string name);
		$display("%s: the cache gave no mem_resp within %0d cycles", name, resp_timeout);
		$display("Simulation FAILED");
		$fatal(1, "response timeout");
	endtask

	// ====================
	// one L1 request
	// ====================
	task automatic run_request(input string name, input logic [7:0] op,
		input l2_addr_pkg::l2_addr_u addr, input logic [line_bits-1:0] wdata,
		input logic [line_bits-1:0] file_data, input logic [miss_count_bits-1:0] file_count);
		logic [l2_addr_pkg::index_bits-1:0] idx;
		l2_addr_pkg::l2_addr_u line_addr;
		l2_addr_pkg::l2_addr_u wb_addr;
		logic miss;
		logic expect_wb;
		int fills_before;
		int wb_before;
		int fills_after;
		int wb_after;
		int waited;
		logic [line_bits-1:0] rdata;
		logic [miss_count_bits-1:0] count;
		idx = addr.fields.index;
		line_addr = addr;
		line_addr.fields.offset = '0;
		wb_addr = line_addr;
		expect_wb = 1'b0;
		miss = !(ref_valid[idx] && ref_tag[idx] == addr.fields.tag);
		if (miss)
		begin
			if (ref_valid[idx] && ref_dirty[idx])
			begin
				expect_wb = 1'b1;
				wb_addr.fields.tag = ref_tag[idx];
				ref_mem[wb_addr.word] = ref_line[idx];
			end
			ref_line[idx] = expected_memory_line(line_addr.word);
			ref_tag[idx] = addr.fields.tag;
			ref_valid[idx] = 1'b1;
			ref_dirty[idx] = 1'b0;
			ref_misses = ref_misses + 1;
		end
		if (op == op_write)
		begin
			ref_line[idx] = wdata;
			ref_dirty[idx] = 1'b1;
		end
		fills_before = fill_count;
		wb_before = wb_count;
		@(posedge clk);
		mem_address <= addr;
		mem_wdata <= wdata;
		mem_read <= (op == op_read);
		mem_write <= (op == op_write);
		waited = 0;
		@(negedge clk);
		while (!mem_resp)
		begin
			if (waited == resp_timeout)
				report_timeout(name);
			waited = waited + 1;
			@(negedge clk);
		end
		rdata = mem_rdata;
		count = miss_count;
		fills_after = fill_count;
		wb_after = wb_count;
		@(posedge clk);
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		check_count({name, " miss_count"}, ref_misses, count);
		check_count({name, " miss_count from file"}, file_count, count);
		check_count({name, " memory fills"}, miss, fills_after - fills_before);
		check_count({name, " writebacks"}, expect_wb, wb_after - wb_before);
		if (op == op_read)
		begin
			check_line({name, " read data"}, ref_line[idx], rdata);
			check_line({name, " read data from file"}, file_data, rdata);
		end
		if (expect_wb)
		begin
			check_addr({name, " writeback address"}, wb_addr, last_wb_addr);
			check_line({name, " writeback data"}, ref_mem[wb_addr.word], last_wb_data);
			check_line({name, " memory after writeback"}, ref_mem[wb_addr.word],
				memory_line(wb_addr.word));
		end
	endtask

	initial
	begin
		int rec;
		int base;
		int records_run;
		logic [7:0] op;
		rst = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		ref_valid = '0;
		ref_dirty = '0;
		ref_misses = 0;
		records_run = 0;
		$readmemh("sim/l2_cache_patterns.txt", patterns);
		for (rec = 0; rec < reset_cycles; rec++)
			@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("reset mem_resp", 1'b0, mem_resp);
		check_flag("reset pmem_read", 1'b0, pmem_read);
		check_flag("reset pmem_write", 1'b0, pmem_write);
		check_count("reset miss_count", '0, miss_count);
		for (rec = 0; rec < pattern_words / record_words; rec++)
		begin
			base = rec * record_words;
			op = patterns[base][7:0];
			if (op !== op_read && op !== op_write)
				break;
			run_request($sformatf("record %0d", rec), op, patterns[base + 1][31:0],
				patterns[base + 3], patterns[base + 4],
				patterns[base + 2][miss_count_bits-1:0]);
			records_run = records_run + 1;
		end
		if (records_run == 0)
		begin
			$display("the pattern file held no requests");
			$display("Simulation FAILED");
			$fatal(1, "empty pattern file");
		end
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim/l2_cache_patterns.txt */
// op (1 read, 2 write), address, expected miss_count
// then the write data line, then the expected read data line
1 00000100 1
0
0000010000000100000001000000010000000100000001000000010000000100
2 00000104 1
1111111122222222333333334444444455555555666666667777777788888888
0
1 00000100 1
0
1111111122222222333333334444444455555555666666667777777788888888
1 00000200 2
0
0000020000000200000002000000020000000200000002000000020000000200
1 00000100 3
0
1111111122222222333333334444444455555555666666667777777788888888
1 00000020 4
0
0000002000000020000000200000002000000020000000200000002000000020
2 00000020 4
deadbeefcafef00d0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a
0
1 00000020 4
0
deadbeefcafef00d0123456789abcdeffedcba9876543210a5a5a5a55a5a5a5a

/* list.f */
src/l2_addr_pkg.sv
src/l2_ctrl_pkg.sv
src/l2_cache_control.sv
src/l2_tag_array.sv
src/l2_data_array.sv
src/l2_pmem_addr_gen.sv
src/l2_cache.sv
sim/l2_cache_assertions.sv
sim/l2_cache_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module l2_cache_tb \
	-o l2_cache_sim
./obj_dir/l2_cache_sim
